//--- sort_defines.svh
`ifndef SORT_DEFINES_SVH
`define SORT_DEFINES_SVH

// ==========================================================
// Batch geometry
// ==========================================================

// Entries per batch
`define SORT_ENTRIES 8

// Field widths of one entry
`define SORT_CHAR_W 4
`define SORT_WEIGHT_W 5

// Flat bus widths at the top level
`define SORT_CHAR_BUS_W (`SORT_ENTRIES * `SORT_CHAR_W)
`define SORT_WEIGHT_BUS_W (`SORT_ENTRIES * `SORT_WEIGHT_W)

`endif

//--- sort_pkg.sv
`default_nettype none

`include "sort_defines.svh"

package sort_pkg;

    // Weight sits above the character so the entry reads as one sort key
    typedef struct packed {
        logic [`SORT_WEIGHT_W-1:0] weight;
        logic [`SORT_CHAR_W-1:0]   character;
    } sort_entry_t;

    // Lane 0 holds rank 0 once the network has settled
    typedef sort_entry_t [`SORT_ENTRIES-1:0] sort_lanes_t;

    typedef struct packed {
        logic        valid;
        sort_lanes_t lanes;
    } sort_batch_t;

    // Heavier first, then larger character on a tie
    function automatic logic entry_outranks(sort_entry_t a, sort_entry_t b);
        return (a.weight > b.weight) ||
               ((a.weight == b.weight) && (a.character > b.character));
    endfunction

    // One comparator, winner goes to the lower lane
    function automatic sort_lanes_t compare_swap(sort_lanes_t lanes,
                                                 int unsigned lane_lo,
                                                 int unsigned lane_hi);
        sort_lanes_t result;
        result = lanes;
        if (entry_outranks(lanes[lane_hi], lanes[lane_lo])) begin
            result[lane_lo] = lanes[lane_hi];
            result[lane_hi] = lanes[lane_lo];
        end
        return result;
    endfunction

endpackage

`default_nettype wire

//--- sort_input_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "sort_defines.svh"

module sort_input_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  logic [`SORT_CHAR_BUS_W-1:0]   in_character,
    input  logic [`SORT_WEIGHT_BUS_W-1:0] in_weight,
    output sort_pkg::sort_batch_t         stage1
);

    import sort_pkg::*;

    sort_lanes_t lanes_in;
    sort_lanes_t layer1;
    sort_lanes_t layer2;

    logic        valid_q;
    sort_lanes_t lanes_q;

    // ==========================================================
    // Unpack flat buses, entry 0 in the top bits
    // ==========================================================

    always_comb begin
        for (int i = 0; i < `SORT_ENTRIES; i++) begin
            lanes_in[i].character =
                in_character[(`SORT_ENTRIES-1-i)*`SORT_CHAR_W +: `SORT_CHAR_W];
            lanes_in[i].weight =
                in_weight[(`SORT_ENTRIES-1-i)*`SORT_WEIGHT_W +: `SORT_WEIGHT_W];
        end
    end

    // ==========================================================
    // Comparator layers 1 and 2
    // ==========================================================

    always_comb begin
        layer1 = compare_swap(lanes_in, 1, 3);
        layer1 = compare_swap(layer1, 4, 6);
        layer1 = compare_swap(layer1, 0, 2);
        layer1 = compare_swap(layer1, 5, 7);
    end

    // Even lanes meet even, odd meet odd
    always_comb begin
        layer2 = compare_swap(layer1, 0, 4);
        layer2 = compare_swap(layer2, 1, 5);
        layer2 = compare_swap(layer2, 2, 6);
        layer2 = compare_swap(layer2, 3, 7);
    end

    // ==========================================================
    // Pipeline register
    // ==========================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    // Holds the last batch between strobes
    always_ff @(posedge clk) begin
        if (in_valid) begin
            lanes_q <= layer2;
        end
    end

    assign stage1 = '{valid: valid_q, lanes: lanes_q};

    // Strobed input must be fully defined
    a_input_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        in_valid |-> !$isunknown({in_character, in_weight})
    );

endmodule

`default_nettype wire

//--- sort_merge_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "sort_defines.svh"

module sort_merge_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  sort_pkg::sort_batch_t stage1,
    output sort_pkg::sort_batch_t stage2
);

    import sort_pkg::*;

    sort_lanes_t layer3;
    sort_lanes_t layer4;
    logic        lane0_on_top;

    logic        valid_q;
    sort_lanes_t lanes_q;

    // ==========================================================
    // Comparator layers 3 and 4
    // ==========================================================

    // Neighbour pairs
    always_comb begin
        layer3 = compare_swap(stage1.lanes, 0, 1);
        layer3 = compare_swap(layer3, 2, 3);
        layer3 = compare_swap(layer3, 4, 5);
        layer3 = compare_swap(layer3, 6, 7);
    end

    always_comb begin
        layer4 = compare_swap(layer3, 2, 4);
        layer4 = compare_swap(layer4, 3, 5);
    end

    // After layer 3 the batch maximum has reached lane 0
    always_comb begin
        lane0_on_top = 1'b1;
        for (int k = 1; k < `SORT_ENTRIES; k++) begin
            if (entry_outranks(layer3[k], layer3[0])) begin
                lane0_on_top = 1'b0;
            end
        end
    end

    // ==========================================================
    // Pipeline register
    // ==========================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= stage1.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (stage1.valid) begin
            lanes_q <= layer4;
        end
    end

    assign stage2 = '{valid: valid_q, lanes: lanes_q};

    // Relies on the layer 1 and 2 wiring upstream
    a_max_in_lane0: assert property (
        @(posedge clk) disable iff (!rst_n)
        stage1.valid |-> lane0_on_top
    );

endmodule

`default_nettype wire

//--- sort_output_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "sort_defines.svh"

module sort_output_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  sort_pkg::sort_batch_t       stage2,
    output logic                        out_valid,
    output logic [`SORT_CHAR_BUS_W-1:0] out_character
);

    import sort_pkg::*;

    sort_lanes_t layer5;
    sort_lanes_t layer6;

    // Full entries kept so the ordering can be checked
    sort_lanes_t ranked_q;
    logic        ranked_ordered;

    // ==========================================================
    // Comparator layers 5 and 6
    // ==========================================================

    always_comb begin
        layer5 = compare_swap(stage2.lanes, 1, 4);
        layer5 = compare_swap(layer5, 3, 6);
    end

    // Last touch-up, lane k now holds rank k
    always_comb begin
        layer6 = compare_swap(layer5, 1, 2);
        layer6 = compare_swap(layer6, 3, 4);
        layer6 = compare_swap(layer6, 5, 6);
    end

    // ==========================================================
    // Output register
    // ==========================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= stage2.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (stage2.valid) begin
            ranked_q <= layer6;
        end
    end

    // Weights dropped, rank 0 in the top nibble
    always_comb begin
        for (int k = 0; k < `SORT_ENTRIES; k++) begin
            out_character[(`SORT_ENTRIES-1-k)*`SORT_CHAR_W +: `SORT_CHAR_W] =
                ranked_q[k].character;
        end
    end

    // ==========================================================
    // Ordering check
    // ==========================================================

    always_comb begin
        ranked_ordered = 1'b1;
        for (int k = 1; k < `SORT_ENTRIES; k++) begin
            if (entry_outranks(ranked_q[k], ranked_q[k-1])) begin
                ranked_ordered = 1'b0;
            end
        end
    end

    // Covers the whole six-layer network across all three stages
    a_ranked_order: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid |-> ranked_ordered
    );

endmodule

`default_nettype wire

//--- sort_ip.sv
`timescale 1ns/1ps
`default_nettype none

`include "sort_defines.svh"

module sort_ip (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  logic [`SORT_CHAR_BUS_W-1:0]   in_character,
    input  logic [`SORT_WEIGHT_BUS_W-1:0] in_weight,
    output logic                          out_valid,
    output logic [`SORT_CHAR_BUS_W-1:0]   out_character
);

    import sort_pkg::*;

    sort_batch_t stage1;
    sort_batch_t stage2;

    // ==========================================================
    // Three-stage sorting pipeline
    // ==========================================================

    // Unpack plus layers 1 and 2
    sort_input_stage sort_input_stage_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_character (in_character),
        .in_weight    (in_weight),
        .stage1       (stage1)
    );

    // Layers 3 and 4
    sort_merge_stage sort_merge_stage_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .stage1 (stage1),
        .stage2 (stage2)
    );

    // Layers 5 and 6, then pack
    sort_output_stage sort_output_stage_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .stage2        (stage2),
        .out_valid     (out_valid),
        .out_character (out_character)
    );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int period_ns = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(period_ns / 2) clk = ~clk;

endmodule

`default_nettype wire

//--- tb_sort_ip.sv
`timescale 1ns/1ps
`default_nettype none

`include "sort_defines.svh"

module tb_sort_ip;

    localparam int clk_period_ns = 40;
    localparam int reset_cycles = 8;
    // Reset, idle, two directed, hold, random stream
    localparam int test_cycles = reset_cycles + 20 + 20 + 40 + 30 + 220;
    localparam int margin_cycles = 100;
    localparam int drain_limit = 20;

    logic                          clk;
    logic                          rst_n;
    logic                          in_valid;
    logic [`SORT_CHAR_BUS_W-1:0]   in_character;
    logic [`SORT_WEIGHT_BUS_W-1:0] in_weight;
    logic                          out_valid;
    logic [`SORT_CHAR_BUS_W-1:0]   out_character;

    logic [31:0] expected_q[$];
    logic [15:0] lfsr_state;
    int          error_count;
    int          check_count;
    int          test_count;
    int          pulse_count;
    int          run_length;
    logic        prev_valid;

    tb_clock_gen #(.period_ns(clk_period_ns)) tb_clock_gen_i (.clk(clk));

    sort_ip sort_ip_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_character  (in_character),
        .in_weight     (in_weight),
        .out_valid     (out_valid),
        .out_character (out_character)
    );

    // ==========================================================
    // Reference model and random source
    // ==========================================================

    // Heavier first, larger character breaks a tie
    function automatic logic [31:0] rank_characters(logic [31:0] chars, logic [39:0] weights);
        logic [3:0]  c [8];
        logic [4:0]  w [8];
        logic [3:0]  tc;
        logic [4:0]  tw;
        logic [31:0] packed_word;
        for (int i = 0; i < 8; i++) begin
            c[i] = chars[(7 - i) * 4 +: 4];
            w[i] = weights[(7 - i) * 5 +: 5];
        end
        for (int i = 0; i < 7; i++) begin
            for (int j = 0; j < 7 - i; j++) begin
                if ((w[j + 1] > w[j]) || ((w[j + 1] == w[j]) && (c[j + 1] > c[j]))) begin
                    tc = c[j];
                    tw = w[j];
                    c[j] = c[j + 1];
                    w[j] = w[j + 1];
                    c[j + 1] = tc;
                    w[j + 1] = tw;
                end
            end
        end
        for (int k = 0; k < 8; k++) begin
            packed_word[(7 - k) * 4 +: 4] = c[k];
        end
        return packed_word;
    endfunction

    // Galois LFSR, one step per bit
    function automatic logic [39:0] next_bits(int count);
        logic [39:0] result;
        logic        lsb;
        result = '0;
        for (int i = 0; i < count; i++) begin
            lsb = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb) begin
                lfsr_state = lfsr_state ^ 16'hB400;
            end
            result = {result[38:0], lsb};
        end
        return result;
    endfunction

    // ==========================================================
    // Output monitor
    // ==========================================================

    always @(negedge clk) begin
        logic [31:0] expected;
        if (out_valid === 1'b1) begin
            pulse_count++;
            run_length = prev_valid ? run_length + 1 : 1;
            if (expected_q.size() == 0) begin
                $display("ERROR at %0t ns: out_valid pulsed with no batch outstanding", $time);
                error_count++;
            end else begin
                expected = expected_q.pop_front();
                check_count++;
                if (out_character !== expected) begin
                    $display("CHECK FAILED at %0t ns: out_character expected %h, got %h",
                             $time, expected, out_character);
                    error_count++;
                end
            end
        end
        prev_valid = (out_valid === 1'b1);
    end

    // ==========================================================
    // Driver helpers
    // ==========================================================

    task automatic send_batch(logic [31:0] chars, logic [39:0] weights, logic [31:0] expected);
        @(negedge clk);
        in_valid = 1'b1;
        in_character = chars;
        in_weight = weights;
        expected_q.push_back(expected);
        if (rank_characters(chars, weights) != expected) begin
            $display("ERROR at %0t ns: reference model disagrees with directed value %h",
                     $time, expected);
            error_count++;
        end
    endtask

    task automatic release_inputs();
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // Wait until every sent batch has come out
    task automatic wait_for_drain();
        int cycles;
        cycles = 0;
        while (expected_q.size() != 0 && cycles < drain_limit) begin
            @(posedge clk);
            cycles++;
        end
        if (expected_q.size() != 0) begin
            $display("ERROR at %0t ns: %0d batches never came out", $time, expected_q.size());
            error_count++;
            expected_q.delete();
        end
        @(negedge clk);
    endtask

    task automatic report_test(string name, int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    // ==========================================================
    // Tests
    // ==========================================================

    task automatic test_idle_after_reset();
        int errors_before;
        errors_before = error_count;
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check_count++;
            if (out_valid !== 1'b0) begin
                $display("CHECK FAILED at %0t ns: out_valid expected 0, got %b", $time, out_valid);
                error_count++;
            end
        end
        report_test("idle_after_reset", errors_before);
    endtask

    task automatic test_distinct_weights();
        int errors_before;
        int latency;
        errors_before = error_count;
        send_batch(32'h0123_4567, {5'd3, 5'd17, 5'd9, 5'd30, 5'd1, 5'd22, 5'd12, 5'd5},
                   32'h3516_2704);
        latency = 0;
        do begin
            @(negedge clk);
            latency++;
            if (latency == 1) begin
                in_valid = 1'b0;
            end
        end while (out_valid !== 1'b1 && latency < drain_limit);
        check_count++;
        if (latency != 3) begin
            $display("CHECK FAILED at %0t ns: latency expected 3, got %0d", $time, latency);
            error_count++;
        end
        wait_for_drain();
        report_test("distinct_weights", errors_before);
    endtask

    task automatic test_tied_weights();
        int errors_before;
        errors_before = error_count;
        send_batch(32'h3A5F_0C18, {8{5'd7}}, 32'hFCA8_5310);
        release_inputs();
        wait_for_drain();
        send_batch(32'h1234_5678, {5'd9, 5'd4, 5'd9, 5'd20, 5'd4, 5'd9, 5'd0, 5'd20},
                   32'h8463_1527);
        release_inputs();
        wait_for_drain();
        report_test("tied_weights", errors_before);
    endtask

    task automatic test_output_hold();
        int          errors_before;
        int          pulses_before;
        logic [31:0] held;
        errors_before = error_count;
        pulses_before = pulse_count;
        // Ties at 16 and at 8 resolve by character
        held = 32'h9C20_B74E;
        send_batch(32'h9E27_B4C0, {5'd31, 5'd0, 5'd16, 5'd8, 5'd8, 5'd2, 5'd25, 5'd16},
                   held);
        release_inputs();
        wait_for_drain();
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            check_count++;
            if (out_character !== held) begin
                $display("CHECK FAILED at %0t ns: out_character expected %h held, got %h",
                         $time, held, out_character);
                error_count++;
            end
            check_count++;
            if (out_valid !== 1'b0) begin
                $display("CHECK FAILED at %0t ns: out_valid expected 0, got %b",
                         $time, out_valid);
                error_count++;
            end
        end
        check_count++;
        if (pulse_count - pulses_before != 1) begin
            $display("CHECK FAILED at %0t ns: out_valid pulses expected 1, got %0d",
                     $time, pulse_count - pulses_before);
            error_count++;
        end
        report_test("output_hold", errors_before);
    endtask

    task automatic test_random_stream();
        int          errors_before;
        int          pulses_before;
        logic [39:0] rnd;
        logic [31:0] chars;
        logic [39:0] weights;
        errors_before = error_count;
        pulses_before = pulse_count;
        for (int n = 0; n < 200; n++) begin
            rnd = next_bits(32);
            chars = rnd[31:0];
            weights = next_bits(40);
            send_batch(chars, weights, rank_characters(chars, weights));
        end
        release_inputs();
        wait_for_drain();
        check_count++;
        if (pulse_count - pulses_before != 200 || run_length != 200) begin
            $display("CHECK FAILED at %0t ns: pulse count expected 200, got %0d (run %0d)",
                     $time, pulse_count - pulses_before, run_length);
            error_count++;
        end
        report_test("random_stream", errors_before);
    endtask

    // ==========================================================
    // Sequence and watchdog
    // ==========================================================

    initial begin
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_character = '0;
        in_weight = '0;
        lfsr_state = 16'd22;
        error_count = 0;
        check_count = 0;
        test_count = 0;
        pulse_count = 0;
        run_length = 0;
        prev_valid = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
        test_idle_after_reset();
        test_distinct_weights();
        test_tied_weights();
        test_output_hold();
        test_random_stream();
        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(clk_period_ns * (test_cycles + margin_cycles));
        $display("ERROR at %0t ns: watchdog expired before the tests finished", $time);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
sort_pkg.sv
sort_input_stage.sv
sort_merge_stage.sv
sort_output_stage.sv
sort_ip.sv
tb_clock_gen.sv
tb_sort_ip.sv

//--- Makefile
TOP := tb_sort_ip

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module sort_ip -f tb.f
	verilator --lint-only --timing --top-module $(TOP) -f tb.f

obj_dir/V$(TOP): tb.f *.sv *.svh
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f

# The run passes only if the pass message shows up in the output
sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
